/* design/psx_mem_pkg.sv */
// memory map offsets, download indices and memory word types
// shared by the loader, port mux and backup path

package psx_mem_pkg;

	// ========================================
	// word types
	// ========================================

	// byte address into unified ram
	typedef logic [26:0] mem_addr_t;
	// one sdram data word
	typedef logic [31:0] mem_word_t;
	typedef logic [3:0]  mem_be_t;
	// host download word, also backup buffer width
	typedef logic [15:0] half_word_t;

	// ========================================
	// memory map
	// ========================================

	// bios image lands at 2 MiB
	localparam mem_addr_t BIOS_START = 27'd2097152;
	// executables land at 4 MiB
	localparam mem_addr_t EXE_START = 27'd4194304;

	// download index codes from the host menu
	localparam logic [7:0] BIOS_INDEX = 8'd0;
	// cheat codes use this slot, not handled here
	localparam logic [7:0] CODE_INDEX = 8'd255;

endpackage

/* design/psx_video_pkg.sv */
// framebuffer placement, format codes and video field types
// used by the geometry block and the top level

package psx_video_pkg;

	// framebuffer width, height
	typedef logic [11:0] fb_dim_t;
	// one aspect ratio term for the scaler
	typedef logic [11:0] ar_t;

	// ========================================
	// framebuffer layout
	// ========================================

	// vram mirror in ddr
	localparam logic [31:0] FB_BASE_ADDR = 32'h3000_0000;
	// 1024 pixels of 2 bytes per row
	localparam logic [31:0] FB_STRIDE_BYTES = 32'd2048;

	// whole vram shown in viewer mode
	localparam fb_dim_t VRAM_WIDTH = 12'd1024;
	localparam fb_dim_t VRAM_HEIGHT = 12'd512;

	// format codes
	// 16bpp 1555 rgb
	localparam logic [4:0] FB_FMT_16 = 5'b01100;
	// 24bpp rgb
	localparam logic [4:0] FB_FMT_24 = 5'b00101;

endpackage

/* design/mem_wr_if.sv */
// loader write channel interface and backup buffer port interface
`timescale 1ns/1ps

// loader to port mux, one word per req/ack pair
interface mem_wr_if import psx_mem_pkg::*; ();
	mem_addr_t addr;
	mem_word_t data;
	logic      req;
	logic      ack;
	// bios or exe download running
	logic      active;

	modport loader (output addr, data, req, active, input ack);
	modport mux (input addr, data, req, active, output ack);
endinterface

// sequencer side of the backup buffer
interface bram_port_if import psx_mem_pkg::*; #(parameter int BRAM_ADDR_W = 8) ();
	logic [BRAM_ADDR_W-1:0] addr;
	half_word_t             wdata;
	logic                   we;
	// valid one cycle after addr
	half_word_t             rdata;

	modport master (output addr, wdata, we, input rdata);
	modport slave (input addr, wdata, we, output rdata);
endinterface

/* design/ioctl_loader.sv */
// rom download handling, type detect and 16 to 32 bit word packing
`timescale 1ns/1ps

module ioctl_loader
	import psx_mem_pkg::*;
(
	input  logic       clk_1x,
	input  logic       arst_n,
	input  logic       ioctl_download,
	input  logic [7:0] ioctl_index,
	input  logic       ioctl_wr,
	input  mem_addr_t  ioctl_addr,
	input  half_word_t ioctl_dout,
	output logic       ioctl_wait,
	output logic       load_exe,
	output logic       cart_loaded,
	mem_wr_if.loader   wr
);

	logic bios_dl;
	logic exe_dl;
	logic exe_dl_q;
	logic exe_index;

	// anything but bios and cheat codes counts as an executable
	assign exe_index = (ioctl_index != BIOS_INDEX) && (ioctl_index != CODE_INDEX);

	// ========================================
	// download type flags
	// ========================================

	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			bios_dl <= 1'b0;
			exe_dl <= 1'b0;
			exe_dl_q <= 1'b0;
			load_exe <= 1'b0;
			cart_loaded <= 1'b0;
		end else begin
			bios_dl <= ioctl_download && (ioctl_index == BIOS_INDEX);
			exe_dl <= ioctl_download && exe_index;
			exe_dl_q <= exe_dl;
			// falling edge of exe download starts the core
			load_exe <= exe_dl_q && !exe_dl;
			// index 1 is the exe slot in the menu
			if (ioctl_download && (ioctl_index == 8'd1)) begin
				cart_loaded <= 1'b1;
			end
		end
	end

	assign wr.active = bios_dl || exe_dl;

	// ========================================
	// host wait and write strobe
	// ========================================

	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			wr.req <= 1'b0;
			ioctl_wait <= 1'b0;
		end else begin
			wr.req <= 1'b0;
			if (wr.active) begin
				// high half completes the word
				if (ioctl_wr && ioctl_addr[1]) begin
					wr.req <= 1'b1;
					ioctl_wait <= 1'b1;
				end
				if (wr.ack) begin
					ioctl_wait <= 1'b0;
				end
			end else begin
				// end of download releases the host
				ioctl_wait <= 1'b0;
			end
		end
	end

	// word assembly, low half also fixes the target address
	always_ff @(posedge clk_1x) begin
		if (wr.active && ioctl_wr) begin
			if (!ioctl_addr[1]) begin
				wr.data[15:0] <= ioctl_dout;
				wr.addr <= ioctl_addr + (bios_dl ? BIOS_START : EXE_START);
			end else begin
				wr.data[31:16] <= ioctl_dout;
			end
		end
	end

	// host must hold off while memory is busy with the last word
	a_no_wr_during_wait: assert property (@(posedge clk_1x) disable iff (!arst_n)
		ioctl_wait |-> !ioctl_wr);

endmodule

/* design/sdram_port_mux.sv */
// core and loader request routing onto sdram read and write channels
`timescale 1ns/1ps

module sdram_port_mux
	import psx_mem_pkg::*;
(
	mem_wr_if.mux      m,
	input  mem_addr_t  core_addr,
	input  mem_word_t  core_din,
	input  mem_be_t    core_be,
	input  logic       core_req,
	input  logic       core_rnw,
	output logic       core_ack,
	output mem_addr_t  rd_addr,
	output logic       rd_req,
	input  logic       rd_ready,
	output mem_addr_t  wr_addr,
	output mem_word_t  wr_data,
	output mem_be_t    wr_be,
	output logic       wr_req,
	input  logic       wr_ready
);

	// ========================================
	// read channel
	// ========================================

	// core only, loader never reads
	assign rd_addr = core_addr;
	assign rd_req = core_req && core_rnw && !m.active;

	// ========================================
	// write channel
	// ========================================

	// loader owns the channel for the whole download
	assign wr_addr = m.active ? m.addr : core_addr;
	assign wr_data = m.active ? m.data : core_din;
	// download words are always full width
	assign wr_be = m.active ? '1 : core_be;
	assign wr_req = m.active ? m.req : (core_req && !core_rnw);

	// acks go back to whoever issued
	assign m.ack = m.active && wr_ready;
	assign core_ack = !m.active && (rd_ready || wr_ready);

	// core is held in reset by the host while a download runs
	always_comb begin
		a_no_core_during_dl: assert final (!(core_req === 1'b1 && m.active === 1'b1));
	end

endmodule

/* design/backup_sequencer.sv */
// backup ram sector walker between memory and the dual port buffer
`timescale 1ns/1ps

module backup_sequencer
	import psx_mem_pkg::*;
#(
	parameter int BRAM_ADDR_W = 8
) (
	input  logic                   clk_1x,
	input  logic                   arst_n,
	input  logic                   bk_start,
	input  logic                   bk_loading,
	output logic                   bk_finish,
	output logic [BRAM_ADDR_W-1:0] word_addr,
	output logic                   bram_mem_req,
	output logic                   bram_mem_rnw,
	output half_word_t             bram_mem_dout,
	input  half_word_t             bram_mem_din,
	input  logic                   bram_mem_ready,
	bram_port_if.master            b
);

	// high from req until ready
	logic waiting;

	// ========================================
	// request / wait fsm
	// ========================================

	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			word_addr <= '0;
			waiting <= 1'b0;
			bk_finish <= 1'b0;
			bram_mem_req <= 1'b0;
		end else begin
			bram_mem_req <= 1'b0;
			if (!bk_start) begin
				// idle rewinds to the first word
				word_addr <= '0;
				waiting <= 1'b0;
				bk_finish <= 1'b0;
			end else if (!bk_finish) begin
				if (!waiting) begin
					bram_mem_req <= 1'b1;
					waiting <= 1'b1;
				end else if (bram_mem_ready) begin
					waiting <= 1'b0;
					// last address ends the sector
					if (&word_addr) begin
						bk_finish <= 1'b1;
					end else begin
						word_addr <= word_addr + 1'b1;
					end
				end
			end
		end
	end

	// load reads memory and save writes it
	assign bram_mem_rnw = bk_loading;

	// buffer side
	assign b.addr = word_addr;
	assign b.wdata = bram_mem_din;
	// capture returned word in the ready cycle
	assign b.we = bk_loading && waiting && bram_mem_ready;
	// save data valid in the req cycle
	assign bram_mem_dout = b.rdata;

	// one word in flight at a time
	a_single_outstanding: assert property (@(posedge clk_1x) disable iff (!arst_n)
		bram_mem_req |=> (!bram_mem_req until bram_mem_ready));

endmodule

/* design/backup_buffer.sv */
// true dual port 16 bit backup buffer, sequencer port and sd port
`timescale 1ns/1ps

module backup_buffer
	import psx_mem_pkg::*;
#(
	parameter int BRAM_ADDR_W = 8
) (
	input  logic                   clk_1x,
	bram_port_if.slave             b,
	input  logic [BRAM_ADDR_W-1:0] sd_buff_addr,
	input  half_word_t             sd_buff_dout,
	input  logic                   sd_buff_wr,
	output half_word_t             sd_buff_din
);

	// one sector
	half_word_t mem [2**BRAM_ADDR_W];

	// registered read addresses
	logic [BRAM_ADDR_W-1:0] addr_a_q;
	logic [BRAM_ADDR_W-1:0] addr_b_q;

	always_ff @(posedge clk_1x) begin
		if (b.we) begin
			mem[b.addr] <= b.wdata;
		end
		// sd side wins on a same address collision
		if (sd_buff_wr) begin
			mem[sd_buff_addr] <= sd_buff_dout;
		end
		addr_a_q <= b.addr;
		addr_b_q <= sd_buff_addr;
	end

	// unregistered outputs, new data on read after write
	assign b.rdata = mem[addr_a_q];
	assign sd_buff_din = mem[addr_b_q];

endmodule

/* design/video_geometry.sv */
// framebuffer base, size and format, aspect ratio and scaler decode
`timescale 1ns/1ps

module video_geometry
	import psx_video_pkg::*;
(
	input  logic        clk_1x,
	input  logic        arst_n,
	input  logic        color24,
	input  logic        full_vram,
	input  fb_dim_t     display_width,
	input  fb_dim_t     display_height,
	input  logic [9:0]  display_offset_x,
	input  logic [8:0]  display_offset_y,
	input  logic [1:0]  aspect,
	input  logic [2:0]  scale,
	input  logic        forced_scandoubler,
	output logic [31:0] fb_base,
	output logic [4:0]  fb_format,
	output fb_dim_t     fb_width,
	output fb_dim_t     fb_height,
	output ar_t         video_arx,
	output ar_t         video_ary,
	output logic [1:0]  vga_sl,
	output logic        scandoubler,
	output logic        hq2x
);

	logic [31:0] offset_base;
	logic [2:0]  sl_full;

	// 2 bytes per pixel across, one stride per line down
	assign offset_base = FB_BASE_ADDR + 32'(display_offset_x) * 32'd2
		+ 32'(display_offset_y) * FB_STRIDE_BYTES;
	assign sl_full = scale - 3'd1;

	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			fb_base <= '0;
			fb_format <= '0;
			fb_width <= '0;
			fb_height <= '0;
			video_arx <= '0;
			video_ary <= '0;
			vga_sl <= '0;
			scandoubler <= 1'b0;
			hq2x <= 1'b0;
		end else begin
			// ========================================
			// framebuffer
			// ========================================
			fb_base <= full_vram ? FB_BASE_ADDR : offset_base;
			fb_width <= full_vram ? VRAM_WIDTH : display_width;
			fb_height <= full_vram ? VRAM_HEIGHT : display_height;
			fb_format <= color24 ? FB_FMT_24 : FB_FMT_16;
			// original aspect, 2:1 for the vram viewer
			if (aspect == 2'd0) begin
				video_arx <= full_vram ? ar_t'(2) : ar_t'(4);
				video_ary <= full_vram ? ar_t'(1) : ar_t'(3);
			end else begin
				video_arx <= ar_t'(aspect - 2'd1);
				video_ary <= '0;
			end
			// ========================================
			// scaler
			// ========================================
			vga_sl <= (scale != 3'd0) ? sl_full[1:0] : 2'd0;
			scandoubler <= (scale != 3'd0) || forced_scandoubler;
			hq2x <= (scale == 3'd1);
		end
	end

endmodule

/* design/psx_host_top.sv */
// host glue top level, rom loader, memory routing, backup path, video setup
`timescale 1ns/1ps

module psx_host_top
	import psx_mem_pkg::*;
	import psx_video_pkg::*;
#(
	parameter int BRAM_ADDR_W = 8
) (
	input  logic                     clk_1x,
	input  logic                     arst_n,
	// host download
	input  logic                     ioctl_download,
	input  logic [7:0]               ioctl_index,
	input  logic                     ioctl_wr,
	input  mem_addr_t                ioctl_addr,
	input  half_word_t               ioctl_dout,
	output logic                     ioctl_wait,
	output logic                     load_exe,
	output logic                     cart_loaded,
	output logic                     download_active,
	// core memory requests
	input  mem_addr_t                core_addr,
	input  mem_word_t                core_din,
	input  mem_be_t                  core_be,
	input  logic                     core_req,
	input  logic                     core_rnw,
	output logic                     core_ack,
	// sdram channels
	output mem_addr_t                rd_addr,
	output logic                     rd_req,
	input  logic                     rd_ready,
	output mem_addr_t                wr_addr,
	output mem_word_t                wr_data,
	output mem_be_t                  wr_be,
	output logic                     wr_req,
	input  logic                     wr_ready,
	// backup ram transfer
	input  logic                     bk_start,
	input  logic                     bk_loading,
	input  logic [7:0]               bk_lba,
	output logic                     bk_finish,
	output logic [BRAM_ADDR_W+7:0]   bram_mem_addr,
	output logic                     bram_mem_req,
	output logic                     bram_mem_rnw,
	output half_word_t               bram_mem_dout,
	input  half_word_t               bram_mem_din,
	input  logic                     bram_mem_ready,
	// sd side of the buffer
	input  logic [BRAM_ADDR_W-1:0]   sd_buff_addr,
	input  half_word_t               sd_buff_dout,
	input  logic                     sd_buff_wr,
	output half_word_t               sd_buff_din,
	// video
	input  logic                     color24,
	input  logic                     full_vram,
	input  fb_dim_t                  display_width,
	input  fb_dim_t                  display_height,
	input  logic [9:0]               display_offset_x,
	input  logic [8:0]               display_offset_y,
	input  logic [1:0]               aspect,
	input  logic [2:0]               scale,
	input  logic                     forced_scandoubler,
	output logic [31:0]              fb_base,
	output logic [4:0]               fb_format,
	output fb_dim_t                  fb_width,
	output fb_dim_t                  fb_height,
	output ar_t                      video_arx,
	output ar_t                      video_ary,
	output logic [1:0]               vga_sl,
	output logic                     scandoubler,
	output logic                     hq2x
);

	logic [BRAM_ADDR_W-1:0] word_addr;

	mem_wr_if wr_if ();
	bram_port_if #(.BRAM_ADDR_W(BRAM_ADDR_W)) bram_if ();

	// sector number selects the memory block
	assign bram_mem_addr = {bk_lba, word_addr};
	assign download_active = wr_if.active;

	// ========================================
	// rom download and memory routing
	// ========================================

	ioctl_loader ioctl_loader_i (
		.clk_1x         (clk_1x),
		.arst_n         (arst_n),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_wait     (ioctl_wait),
		.load_exe       (load_exe),
		.cart_loaded    (cart_loaded),
		.wr             (wr_if)
	);

	sdram_port_mux sdram_port_mux_i (
		.m         (wr_if),
		.core_addr (core_addr),
		.core_din  (core_din),
		.core_be   (core_be),
		.core_req  (core_req),
		.core_rnw  (core_rnw),
		.core_ack  (core_ack),
		.rd_addr   (rd_addr),
		.rd_req    (rd_req),
		.rd_ready  (rd_ready),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.wr_be     (wr_be),
		.wr_req    (wr_req),
		.wr_ready  (wr_ready)
	);

	// ========================================
	// backup ram path
	// ========================================

	backup_sequencer #(.BRAM_ADDR_W(BRAM_ADDR_W)) backup_sequencer_i (
		.clk_1x         (clk_1x),
		.arst_n         (arst_n),
		.bk_start       (bk_start),
		.bk_loading     (bk_loading),
		.bk_finish      (bk_finish),
		.word_addr      (word_addr),
		.bram_mem_req   (bram_mem_req),
		.bram_mem_rnw   (bram_mem_rnw),
		.bram_mem_dout  (bram_mem_dout),
		.bram_mem_din   (bram_mem_din),
		.bram_mem_ready (bram_mem_ready),
		.b              (bram_if)
	);

	backup_buffer #(.BRAM_ADDR_W(BRAM_ADDR_W)) backup_buffer_i (
		.clk_1x       (clk_1x),
		.b            (bram_if),
		.sd_buff_addr (sd_buff_addr),
		.sd_buff_dout (sd_buff_dout),
		.sd_buff_wr   (sd_buff_wr),
		.sd_buff_din  (sd_buff_din)
	);

	// video setup
	video_geometry video_geometry_i (
		.clk_1x             (clk_1x),
		.arst_n             (arst_n),
		.color24            (color24),
		.full_vram          (full_vram),
		.display_width      (display_width),
		.display_height     (display_height),
		.display_offset_x   (display_offset_x),
		.display_offset_y   (display_offset_y),
		.aspect             (aspect),
		.scale              (scale),
		.forced_scandoubler (forced_scandoubler),
		.fb_base            (fb_base),
		.fb_format          (fb_format),
		.fb_width           (fb_width),
		.fb_height          (fb_height),
		.video_arx          (video_arx),
		.video_ary          (video_ary),
		.vga_sl             (vga_sl),
		.scandoubler        (scandoubler),
		.hq2x               (hq2x)
	);

endmodule

/* verification/psx_host_tb.sv */
// host glue testbench with download, core traffic, backup and video stimulus
// random latency memory models and a reference model for every check
`timescale 1ns/1ps

module psx_host_tb;

	// ========================================
	// reference constants
	// ========================================

	localparam logic [26:0] BIOS_OFS = 27'd2097152;
	localparam logic [26:0] EXE_OFS = 27'd4194304;
	localparam logic [31:0] FB_BASE = 32'h3000_0000;
	localparam int SECTOR_WORDS = 256;
	localparam int SHORT_LIMIT = 64;
	localparam int SECTOR_LIMIT = 5000;

	integer seed = 32'h72622ef1;
	int load_exe_count = 0;

	logic clk_1x = 1'b0;
	logic arst_n;
	// download
	logic ioctl_download, ioctl_wr, ioctl_wait, load_exe, cart_loaded, download_active;
	logic [7:0] ioctl_index;
	logic [26:0] ioctl_addr;
	logic [15:0] ioctl_dout;
	// core and sdram channels
	logic [26:0] core_addr, rd_addr, wr_addr;
	logic [31:0] core_din, wr_data;
	logic [3:0] core_be, wr_be;
	logic core_req, core_rnw, core_ack, rd_req, rd_ready, wr_req, wr_ready;
	// backup path
	logic bk_start, bk_loading, bk_finish, bram_mem_req, bram_mem_rnw, bram_mem_ready;
	logic [7:0] bk_lba, sd_buff_addr;
	logic [15:0] bram_mem_addr, bram_mem_dout, bram_mem_din, sd_buff_dout, sd_buff_din;
	logic sd_buff_wr;
	// video
	logic color24, full_vram, forced_scandoubler, scandoubler, hq2x;
	logic [11:0] display_width, display_height, fb_width, fb_height, video_arx, video_ary;
	logic [9:0] display_offset_x;
	logic [8:0] display_offset_y;
	logic [1:0] aspect, vga_sl;
	logic [2:0] scale;
	logic [31:0] fb_base;
	logic [4:0] fb_format;

	// model logs
	logic [26:0] wr_addr_log[$];
	logic [31:0] wr_data_log[$];
	logic [3:0] wr_be_log[$];
	logic [26:0] rd_addr_log[$];
	logic [15:0] bk_addr_log[$];
	logic bk_rnw_log[$];
	logic [15:0] bk_dout_log[$];
	logic [15:0] bk_given[$];
	logic [15:0] fill_words[$];

	psx_host_top #(.BRAM_ADDR_W(8)) dut_i (.*);

	always #4 clk_1x = ~clk_1x;

	// ========================================
	// failure reporting
	// ========================================

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic check_equal(input logic [63:0] got, input logic [63:0] exp,
		input string what);
		if (got !== exp) begin
			stop_run($sformatf("FAIL at %0t: %s, got 0x%0h expected 0x%0h",
				$time, what, got, exp));
		end
	endtask

	// ========================================
	// memory models
	// ========================================

	// sdram write channel logs each request and acks 1 to 8 cycles later
	initial begin
		int d;
		wr_ready = 1'b0;
		forever begin
			@(negedge clk_1x);
			if (arst_n && wr_req) begin
				wr_addr_log.push_back(wr_addr);
				wr_data_log.push_back(wr_data);
				wr_be_log.push_back(wr_be);
				d = 1 + ($random(seed) & 7);
				repeat (d) @(posedge clk_1x);
				wr_ready <= 1'b1;
				@(posedge clk_1x);
				wr_ready <= 1'b0;
			end
		end
	end

	// sdram read channel
	initial begin
		int d;
		rd_ready = 1'b0;
		forever begin
			@(negedge clk_1x);
			if (arst_n && rd_req) begin
				rd_addr_log.push_back(rd_addr);
				d = 1 + ($random(seed) & 7);
				repeat (d) @(posedge clk_1x);
				rd_ready <= 1'b1;
				@(posedge clk_1x);
				rd_ready <= 1'b0;
			end
		end
	end

	// backup ram memory returns a random word on a load
	initial begin
		int d;
		logic [15:0] word;
		logic rnw;
		bram_mem_ready = 1'b0;
		bram_mem_din = '0;
		forever begin
			@(negedge clk_1x);
			if (arst_n && bram_mem_req) begin
				rnw = bram_mem_rnw;
				bk_addr_log.push_back(bram_mem_addr);
				bk_rnw_log.push_back(rnw);
				bk_dout_log.push_back(bram_mem_dout);
				word = 16'($random(seed));
				d = 1 + ($random(seed) & 7);
				repeat (d) @(posedge clk_1x);
				bram_mem_ready <= 1'b1;
				bram_mem_din <= word;
				if (rnw) begin
					bk_given.push_back(word);
				end
				@(posedge clk_1x);
				bram_mem_ready <= 1'b0;
			end
		end
	end

	// load_exe pulse count and core_ack masking over the whole run
	always @(negedge clk_1x) begin
		if (arst_n) begin
			if (load_exe) begin
				load_exe_count = load_exe_count + 1;
			end
			if (download_active) begin
				check_equal(core_ack, 0, "core_ack during download");
			end
		end
	end

	// ========================================
	// rom download
	// ========================================

	task automatic download_image(input logic [7:0] index, input logic [26:0] offset,
		input int words);
		int i;
		int t;
		logic acked;
		logic [26:0] base;
		logic [26:0] a;
		logic [15:0] lo;
		logic [15:0] hi;
		base = 27'($random(seed)) & 27'h00f_fffc;
		@(posedge clk_1x);
		ioctl_download <= 1'b1;
		ioctl_index <= index;
		t = 0;
		@(negedge clk_1x);
		while (!download_active) begin
			t++;
			if (t > SHORT_LIMIT) stop_run("timeout: download_active never rose");
			@(negedge clk_1x);
		end
		for (i = 0; i < words; i++) begin
			a = base + 27'(i * 4);
			lo = 16'($random(seed));
			hi = 16'($random(seed));
			@(posedge clk_1x);
			ioctl_wr <= 1'b1;
			ioctl_addr <= a;
			ioctl_dout <= lo;
			@(posedge clk_1x);
			ioctl_addr <= a | 27'd2;
			ioctl_dout <= hi;
			@(posedge clk_1x);
			ioctl_wr <= 1'b0;
			@(negedge clk_1x);
			check_equal(ioctl_wait, 1, "ioctl_wait after the high half");
			// host stays held until memory has acked
			acked = 1'b0;
			t = 0;
			while (ioctl_wait) begin
				if (wr_ready) begin
					acked = 1'b1;
				end
				t++;
				if (t > SHORT_LIMIT) stop_run("timeout: ioctl_wait never fell");
				@(negedge clk_1x);
			end
			check_equal(acked, 1, "ioctl_wait released before wr_ready");
			check_equal(wr_addr_log.size(), 1, "write requests per word pair");
			check_equal(wr_addr_log.pop_front(), a + offset, "download write address");
			check_equal(wr_data_log.pop_front(), {hi, lo}, "download write data");
			check_equal(wr_be_log.pop_front(), 4'hf, "download byte enables");
		end
		@(posedge clk_1x);
		ioctl_download <= 1'b0;
		t = 0;
		@(negedge clk_1x);
		while (download_active) begin
			t++;
			if (t > SHORT_LIMIT) stop_run("timeout: download_active never fell");
			@(negedge clk_1x);
		end
		check_equal(wr_addr_log.size(), 0, "stray write after the download");
	endtask

	// ========================================
	// core traffic
	// ========================================

	task automatic drive_core_requests(input int count);
		int i;
		int t;
		logic rnw;
		logic [26:0] addr;
		logic [31:0] din;
		logic [3:0] be;
		for (i = 0; i < count; i++) begin
			rnw = 1'($random(seed));
			addr = 27'($random(seed));
			din = $random(seed);
			be = 4'($random(seed));
			@(posedge clk_1x);
			core_req <= 1'b1;
			core_rnw <= rnw;
			core_addr <= addr;
			core_din <= din;
			core_be <= be;
			@(negedge clk_1x);
			check_equal(rd_req, rnw, "rd_req for core request");
			check_equal(wr_req, !rnw, "wr_req for core request");
			t = 0;
			while (!core_ack) begin
				t++;
				if (t > SHORT_LIMIT) stop_run("timeout: core_ack never rose");
				@(negedge clk_1x);
			end
			check_equal(rnw ? rd_ready : wr_ready, 1, "core_ack without matching ready");
			@(posedge clk_1x);
			core_req <= 1'b0;
			if (rnw) begin
				check_equal(rd_addr_log.size(), 1, "read requests per core read");
				check_equal(rd_addr_log.pop_front(), addr, "core read address");
				check_equal(wr_addr_log.size(), 0, "write on a core read");
			end else begin
				check_equal(wr_addr_log.size(), 1, "write requests per core write");
				check_equal(wr_addr_log.pop_front(), addr, "core write address");
				check_equal(wr_data_log.pop_front(), din, "core write data");
				check_equal(wr_be_log.pop_front(), be, "core byte enables");
				check_equal(rd_addr_log.size(), 0, "read on a core write");
			end
		end
	endtask

	// ========================================
	// backup ram
	// ========================================

	task automatic fill_buffer();
		int i;
		logic [15:0] w;
		fill_words.delete();
		for (i = 0; i < SECTOR_WORDS; i++) begin
			w = 16'($random(seed));
			fill_words.push_back(w);
			@(posedge clk_1x);
			sd_buff_addr <= 8'(i);
			sd_buff_dout <= w;
			sd_buff_wr <= 1'b1;
		end
		@(posedge clk_1x);
		sd_buff_wr <= 1'b0;
	endtask

	task automatic transfer_sector(input logic loading);
		int i;
		int t;
		logic [7:0] lba;
		lba = 8'($random(seed));
		bk_addr_log.delete();
		bk_rnw_log.delete();
		bk_dout_log.delete();
		bk_given.delete();
		@(posedge clk_1x);
		bk_lba <= lba;
		bk_loading <= loading;
		bk_start <= 1'b1;
		t = 0;
		@(negedge clk_1x);
		while (!bk_finish) begin
			t++;
			if (t > SECTOR_LIMIT) stop_run("timeout: bk_finish never rose");
			@(negedge clk_1x);
		end
		@(posedge clk_1x);
		bk_start <= 1'b0;
		t = 0;
		@(negedge clk_1x);
		while (bk_finish) begin
			t++;
			if (t > SHORT_LIMIT) stop_run("timeout: bk_finish never cleared");
			@(negedge clk_1x);
		end
		check_equal(bk_addr_log.size(), SECTOR_WORDS, "backup requests per sector");
		for (i = 0; i < SECTOR_WORDS; i++) begin
			check_equal(bk_addr_log[i], {lba, 8'(i)}, "backup memory address");
			check_equal(bk_rnw_log[i], loading, "backup read or write select");
			if (!loading) begin
				check_equal(bk_dout_log[i], fill_words[i], "saved backup word");
			end
		end
		// loaded words read back through the sd port
		if (loading) begin
			for (i = 0; i < SECTOR_WORDS; i++) begin
				@(posedge clk_1x);
				sd_buff_addr <= 8'(i);
				@(posedge clk_1x);
				@(negedge clk_1x);
				check_equal(sd_buff_din, bk_given[i], "loaded buffer word");
			end
		end
	endtask

	// ========================================
	// video geometry
	// ========================================

	task automatic sweep_video(input int count);
		int i;
		logic fv;
		logic c24;
		logic [9:0] ox;
		logic [8:0] oy;
		logic [1:0] asp;
		logic [2:0] sc;
		logic [2:0] sc_m1;
		logic fsd;
		logic [11:0] w;
		logic [11:0] h;
		for (i = 0; i < count; i++) begin
			fv = 1'($random(seed));
			c24 = 1'($random(seed));
			ox = 10'($random(seed));
			oy = 9'($random(seed));
			asp = 2'($random(seed));
			sc = 3'($random(seed));
			fsd = 1'($random(seed));
			w = 12'($random(seed));
			h = 12'($random(seed));
			sc_m1 = sc - 3'd1;
			@(posedge clk_1x);
			full_vram <= fv;
			color24 <= c24;
			display_offset_x <= ox;
			display_offset_y <= oy;
			aspect <= asp;
			scale <= sc;
			forced_scandoubler <= fsd;
			display_width <= w;
			display_height <= h;
			@(posedge clk_1x);
			@(negedge clk_1x);
			check_equal(fb_base, fv ? FB_BASE : FB_BASE + 32'(ox) * 2 + 32'(oy) * 2048,
				"fb_base");
			check_equal(fb_width, fv ? 12'd1024 : w, "fb_width");
			check_equal(fb_height, fv ? 12'd512 : h, "fb_height");
			check_equal(fb_format, c24 ? 5'b00101 : 5'b01100, "fb_format");
			check_equal(video_arx, (asp == 0) ? (fv ? 2 : 4) : asp - 1, "video_arx");
			check_equal(video_ary, (asp == 0) ? (fv ? 1 : 3) : 0, "video_ary");
			check_equal(vga_sl, (sc == 0) ? 2'd0 : sc_m1[1:0], "vga_sl");
			check_equal(scandoubler, (sc != 0) || fsd, "scandoubler");
			check_equal(hq2x, sc == 1, "hq2x");
		end
	endtask

	// ========================================
	// main sequence
	// ========================================

	initial begin
		arst_n = 1'b0;
		ioctl_download = 1'b0;
		ioctl_index = '0;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		core_addr = '0;
		core_din = '0;
		core_be = '0;
		core_req = 1'b0;
		core_rnw = 1'b0;
		bk_start = 1'b0;
		bk_loading = 1'b0;
		bk_lba = '0;
		sd_buff_addr = '0;
		sd_buff_dout = '0;
		sd_buff_wr = 1'b0;
		color24 = 1'b0;
		full_vram = 1'b0;
		display_width = '0;
		display_height = '0;
		display_offset_x = '0;
		display_offset_y = '0;
		aspect = '0;
		scale = '0;
		forced_scandoubler = 1'b0;
		repeat (9) @(posedge clk_1x);
		// outputs held low in reset
		@(negedge clk_1x);
		check_equal({ioctl_wait, wr_req, rd_req, load_exe}, 0, "download outputs in reset");
		check_equal({cart_loaded, bram_mem_req, bk_finish, core_ack}, 0,
			"status outputs in reset");
		@(posedge clk_1x);
		arst_n <= 1'b1;
		repeat (2) @(posedge clk_1x);

		download_image(8'd0, BIOS_OFS, 8 + ($random(seed) & 15));
		repeat (8) @(negedge clk_1x);
		check_equal(load_exe_count, 0, "load_exe after a bios download");
		check_equal(cart_loaded, 0, "cart_loaded after a bios download");

		download_image(8'd1, EXE_OFS, 8 + ($random(seed) & 15));
		begin : exe_start_wait
			int t;
			t = 0;
			while (load_exe_count == 0) begin
				t++;
				if (t > SHORT_LIMIT) stop_run("timeout: load_exe never pulsed");
				@(negedge clk_1x);
			end
		end
		repeat (8) @(negedge clk_1x);
		check_equal(load_exe_count, 1, "load_exe pulses per executable");
		check_equal(cart_loaded, 1, "cart_loaded after an executable");

		drive_core_requests(40);
		transfer_sector(1'b1);
		fill_buffer();
		transfer_sector(1'b0);
		sweep_video(60);

		$display("Testbench passed");
		$finish;
	end

endmodule

/* psx_host.f */
design/psx_mem_pkg.sv
design/psx_video_pkg.sv
design/mem_wr_if.sv
design/ioctl_loader.sv
design/sdram_port_mux.sv
design/backup_sequencer.sv
design/backup_buffer.sv
design/video_geometry.sv
design/psx_host_top.sv
verification/psx_host_tb.sv

/* Bender.yml */
package:
  name: psx_host

sources:
  # packages, then interfaces, then rtl bottom up
  - design/psx_mem_pkg.sv
  - design/psx_video_pkg.sv
  - design/mem_wr_if.sv
  - design/ioctl_loader.sv
  - design/sdram_port_mux.sv
  - design/backup_sequencer.sv
  - design/backup_buffer.sv
  - design/video_geometry.sv
  - design/psx_host_top.sv
  - target: test
    files:
      - verification/psx_host_tb.sv
